//--- sources.f
hdl/cpu_pkg.sv
hdl/fetch_unit.sv
hdl/datapath.sv
hdl/controller.sv
hdl/cpu.sv
test/cpu_props.sv
test/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - files:
      - hdl/cpu_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/datapath.sv
      - hdl/controller.sv
      - hdl/cpu.sv
  - target: test
    files:
      - test/cpu_props.sv
      - test/cpu_tb.sv

//--- test/cpu_tb.sv
// multicycle cpu testbench
`default_nettype none

module cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned addr_w = 9;
	localparam int unsigned mem_words = 2 ** addr_w;
	localparam int n_steps = 40; // each step is one data op or load, then a store

	typedef struct packed {
		logic [addr_w-1:0] addr;
		cpu_pkg::word_t data;
	} store_t;
	typedef store_t store_q_t [$];

	logic clk;
	logic reset;
	cpu_pkg::word_t read_data;
	cpu_pkg::mem_cmd_e mem_cmd;
	logic [addr_w-1:0] mem_addr;
	cpu_pkg::word_t write_data;

	cpu_pkg::word_t mem [mem_words];
	cpu_pkg::word_t ref_image [mem_words];
	store_q_t expected;
	integer seed;
	int n_instr = 0;
	int halt_pc = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	bit after_reset = 1'b0;
	bit started = 1'b0;
	bit halt_fetched = 1'b0;

	cpu #(
		.addr_w(addr_w)
	) dut_i (
		.clk        (clk),
		.reset      (reset),
		.read_data  (read_data),
		.mem_cmd    (mem_cmd),
		.mem_addr   (mem_addr),
		.write_data (write_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		if (mem_cmd == cpu_pkg::mem_read) begin
			read_data <= mem[mem_addr]; // answered in the next cycle
		end else if (mem_cmd == cpu_pkg::mem_write) begin
			mem[mem_addr] <= write_data;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_store(input store_t exp, input logic [addr_w-1:0] addr,
			input cpu_pkg::word_t data);
		if (addr !== exp.addr || data !== exp.data) begin
			abort_run($sformatf("ERROR %0d ns: store of %h at %0d, expected %h at %0d",
				$time, data, addr, exp.data, exp.addr));
		end
	endtask

	task automatic check_idle(input cpu_pkg::mem_cmd_e cmd);
		if (cmd !== cpu_pkg::mem_none) begin
			abort_run($sformatf("ERROR %0d ns: memory command %b where none was expected",
				$time, cmd));
		end
	endtask

	task automatic check_first_fetch(input cpu_pkg::mem_cmd_e cmd, input logic [addr_w-1:0] addr);
		if (cmd !== cpu_pkg::mem_read || addr !== '0) begin
			abort_run($sformatf("ERROR %0d ns: first command %b at %0d, expected a read at 0",
				$time, cmd, addr));
		end
	endtask

	function automatic int unsigned random_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic cpu_pkg::word_t reg_form(input cpu_pkg::opcode_e opc,
			input cpu_pkg::alu_op_e op, input cpu_pkg::reg_idx_t rn, input cpu_pkg::reg_idx_t rd,
			input cpu_pkg::shift_e sh, input cpu_pkg::reg_idx_t rm);
		cpu_pkg::alu_fmt_t f;
		f = '{opcode: opc, op: op, rn: rn, rd: rd, shift: sh, rm: rm};
		return f;
	endfunction

	function automatic cpu_pkg::word_t imm_form(input cpu_pkg::opcode_e opc,
			input logic [1:0] op, input cpu_pkg::reg_idx_t rn, input logic [7:0] imm8);
		cpu_pkg::imm_fmt_t f;
		f = '{opcode: opc, op: op, rn: rn, imm8: imm8};
		return f;
	endfunction

	task automatic write_image(input int addr, input cpu_pkg::word_t value);
		mem[addr] = value;
		ref_image[addr] = value; // reference model gets the same image
	endtask

	task automatic emit(input cpu_pkg::word_t w);
		write_image(n_instr, w);
		n_instr++;
	endtask

	task automatic build_program();
		cpu_pkg::reg_idx_t rd;
		cpu_pkg::reg_idx_t rn;
		cpu_pkg::reg_idx_t rm;
		cpu_pkg::shift_e sh;
		logic [1:0] shift_turn;
		for (int a = 0; a < mem_words; a++) begin
			write_image(a, cpu_pkg::word_t'(a * 16'h0d31) ^ 16'ha5c3);
		end
		for (int a = 184; a <= 215; a++) begin
			write_image(a, cpu_pkg::word_t'($random(seed))); // load data window around 200
		end
		shift_turn = 2'd0;
		emit(imm_form(cpu_pkg::op_move, 2'b10, 3'd7, 8'd100));
		emit(reg_form(cpu_pkg::op_alu, cpu_pkg::alu_add, 3'd7, 3'd7, cpu_pkg::sh_none, 3'd7));
		for (int r = 0; r < 7; r++) begin
			emit(imm_form(cpu_pkg::op_move, 2'b10, cpu_pkg::reg_idx_t'(r), 8'(random_below(256))));
		end
		for (int i = 0; i < n_steps; i++) begin
			rd = cpu_pkg::reg_idx_t'(random_below(7));
			rn = cpu_pkg::reg_idx_t'(random_below(7));
			rm = cpu_pkg::reg_idx_t'(random_below(7));
			sh = cpu_pkg::shift_e'(random_below(4));
			// the first four steps are mov shifted, one per shift code
			case ((i < 4) ? 1 : random_below(6))
				0: emit(imm_form(cpu_pkg::op_move, 2'b10, rd, 8'(random_below(256))));
				1: begin
					emit(reg_form(cpu_pkg::op_move, cpu_pkg::alu_add, rn, rd,
						cpu_pkg::shift_e'(shift_turn), rm)); // walks all four shift codes
					shift_turn++;
				end
				2: emit(reg_form(cpu_pkg::op_alu, cpu_pkg::alu_add, rn, rd, sh, rm));
				3: emit(reg_form(cpu_pkg::op_alu, cpu_pkg::alu_and, rn, rd, sh, rm));
				4: emit(reg_form(cpu_pkg::op_alu, cpu_pkg::alu_not, rn, rd, sh, rm));
				default: emit(imm_form(cpu_pkg::op_ldr, 2'b00, 3'd7, {rd, 5'(random_below(32))}));
			endcase
			emit(imm_form(cpu_pkg::op_str, 2'b00, 3'd7, {rd, 5'(random_below(32))}));
		end
		halt_pc = n_instr;
		emit(imm_form(cpu_pkg::op_halt, 2'b00, 3'd0, 8'd0));
	endtask

	function automatic cpu_pkg::word_t shift_operand(input cpu_pkg::word_t v,
			input cpu_pkg::shift_e sh);
		case (sh)
			cpu_pkg::sh_left:  return v << 1;
			cpu_pkg::sh_right: return v >> 1;
			cpu_pkg::sh_arith: return cpu_pkg::word_t'($signed(v) >>> 1);
			default:           return v;
		endcase
	endfunction

	// instruction level model of the program, one instruction per step
	function automatic store_q_t reference_stores();
		store_q_t stores;
		cpu_pkg::word_t rmem [mem_words];
		cpu_pkg::word_t regs [8];
		cpu_pkg::instr_u w;
		cpu_pkg::word_t b;
		logic [addr_w-1:0] pc;
		logic [addr_w-1:0] ea;
		bit running;
		rmem = ref_image;
		foreach (regs[i]) begin
			regs[i] = '0;
		end
		pc = '0;
		running = 1'b1;
		for (int steps = 0; running && steps < mem_words; steps++) begin
			w = rmem[pc];
			pc = pc + 1'b1;
			b = shift_operand(regs[w.alu.rm], w.alu.shift);
			ea = addr_w'(regs[w.imm.rn] + {{11{w.imm.imm8[4]}}, w.imm.imm8[4:0]});
			case ({w.alu.opcode, w.alu.op})
				{cpu_pkg::op_move, 2'b10}: regs[w.imm.rn] = {{8{w.imm.imm8[7]}}, w.imm.imm8};
				{cpu_pkg::op_move, 2'b00}: regs[w.alu.rd] = b;
				{cpu_pkg::op_alu, 2'b00}:  regs[w.alu.rd] = regs[w.alu.rn] + b;
				{cpu_pkg::op_alu, 2'b10}:  regs[w.alu.rd] = regs[w.alu.rn] & b;
				{cpu_pkg::op_alu, 2'b11}:  regs[w.alu.rd] = ~b;
				{cpu_pkg::op_ldr, 2'b00}:  regs[w.alu.rd] = rmem[ea];
				{cpu_pkg::op_str, 2'b00}: begin
					rmem[ea] = regs[w.alu.rd];
					stores.push_back(store_t'{ea, regs[w.alu.rd]});
				end
				default: running = 1'b0; // halt and every undefined word
			endcase
		end
		return stores;
	endfunction

	always @(negedge clk) begin
		store_t next_store;
		if (!reset && mem_cmd == cpu_pkg::mem_write) begin
			if (expected.size() == 0) begin
				abort_run($sformatf("ERROR %0d ns: write at %0d beyond the last store",
					$time, mem_addr));
			end else begin
				next_store = expected.pop_front();
				check_store(next_store, mem_addr, write_data);
			end
		end
	end

	always @(negedge clk) begin
		if (reset) begin
			check_idle(mem_cmd);
			after_reset = 1'b1;
		end else if (after_reset) begin
			check_idle(mem_cmd); // first cycle out of reset
			after_reset = 1'b0;
		end else if (!started && mem_cmd != cpu_pkg::mem_none) begin
			check_first_fetch(mem_cmd, mem_addr);
			started = 1'b1;
		end
		if (!reset && mem_cmd == cpu_pkg::mem_read && mem_addr == addr_w'(halt_pc)) begin
			halt_fetched = 1'b1;
		end
		if (dut_i.u_controller.props_i.assert_failed) begin
			abort_run("a bound assertion on the controller failed");
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			abort_run($sformatf("timeout: the processor did not finish within %0d cycles",
				cycle_limit));
		end
	end

	initial begin
		seed = 32'hed03;
		reset = 1'b1;
		read_data = '0;
		build_program();
		expected = reference_stores();
		cycle_limit = 8 + 10 * n_instr + 50;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		wait (halt_fetched);
		@(negedge clk); // second fetch cycle of the halt word
		repeat (50) begin
			@(negedge clk);
			check_idle(mem_cmd);
		end
		if (expected.size() == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			abort_run($sformatf("%0d expected stores never appeared on the bus",
				expected.size()));
		end
	end

endmodule

`default_nettype wire

//--- test/cpu_props.sv
// memory command assertions
`default_nettype none

module cpu_props (
	input logic              clk,
	input logic              reset,
	input cpu_pkg::mem_cmd_e mem_cmd,
	input logic              reg_write,
	input logic              load_ir,
	input logic              halted
);
	timeunit 1ns;
	timeprecision 100ps;

	logic assert_failed = 1'b0; // sticky, set by any failing property

	quiet_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> mem_cmd == cpu_pkg::mem_none && !reg_write)
	else begin
		assert_failed = 1'b1;
		$error("memory command or register write in the cycle after reset");
	end

	single_write: assert property (@(posedge clk) disable iff (reset)
		mem_cmd == cpu_pkg::mem_write |=> mem_cmd != cpu_pkg::mem_write)
	else begin
		assert_failed = 1'b1;
		$error("mem_write held for two cycles");
	end

	ir_load_on_read: assert property (@(posedge clk) disable iff (reset)
		load_ir |-> mem_cmd == cpu_pkg::mem_read)
	else begin
		assert_failed = 1'b1;
		$error("instruction register loaded outside a read");
	end

	halt_holds: assert property (@(posedge clk) disable iff (reset)
		halted |-> mem_cmd == cpu_pkg::mem_none ##1 halted)
	else begin
		assert_failed = 1'b1;
		$error("controller left halt or issued a command");
	end

endmodule

bind controller cpu_props props_i (
	.clk       (clk),
	.reset     (reset),
	.mem_cmd   (mem_cmd),
	.reg_write (dp_ctrl.write),
	.load_ir   (fetch_ctrl.load_ir),
	.halted    (state == s_halt)
);

`default_nettype wire

//--- hdl/cpu.sv
// multicycle cpu top level
`default_nettype none

module cpu #(
	parameter int unsigned addr_w = 9
) (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::word_t     read_data,
	output cpu_pkg::mem_cmd_e  mem_cmd,
	output logic [addr_w-1:0]  mem_addr,
	output cpu_pkg::word_t     write_data
);

	cpu_pkg::instr_u      instr;
	cpu_pkg::dp_ctrl_t    dp_ctrl;
	cpu_pkg::fetch_ctrl_t fetch_ctrl;

	// the c register feeds both the store data and the data address
	fetch_unit #(
		.addr_w(addr_w)
	) u_fetch (
		.clk           (clk),
		.ctrl          (fetch_ctrl),
		.read_data     (read_data),
		.data_addr_src (write_data),
		.instr         (instr),
		.mem_addr      (mem_addr)
	);

	datapath u_datapath (
		.clk       (clk),
		.ctrl      (dp_ctrl),
		.instr     (instr),
		.read_data (read_data),
		.alu_out   (write_data)
	);

	controller u_controller (
		.clk        (clk),
		.reset      (reset),
		.instr      (instr),
		.dp_ctrl    (dp_ctrl),
		.fetch_ctrl (fetch_ctrl),
		.mem_cmd    (mem_cmd)
	);

endmodule

`default_nettype wire

//--- hdl/controller.sv
// instruction sequencing controller
`default_nettype none

module controller (
	input  logic                  clk,
	input  logic                  reset,
	input  cpu_pkg::instr_u       instr,
	output cpu_pkg::dp_ctrl_t     dp_ctrl,
	output cpu_pkg::fetch_ctrl_t  fetch_ctrl,
	output cpu_pkg::mem_cmd_e     mem_cmd
);

	typedef enum logic [4:0] {
		s_reset,
		s_if1,
		s_if2,
		s_update_pc,
		s_mov_imm,
		s_a_rn,     // load a from rn
		s_b_rm,     // load b from rm
		s_alu,
		s_pass,     // c gets shifted b alone
		s_wb_rd,
		s_addr,     // c gets rn plus imm5
		s_mem_addr,
		s_ld_read,
		s_ld_wb,
		s_st_b,     // load b from rd
		s_st_write,
		s_halt
	} state_e;

	state_e state;
	state_e next_state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_reset;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			s_reset:     next_state = s_if1;
			s_if1:       next_state = s_if2;
			s_if2:       next_state = s_update_pc;
			s_update_pc: begin
				case ({instr.alu.opcode, instr.alu.op})
					{cpu_pkg::op_move, 2'b10}:          next_state = s_mov_imm;
					{cpu_pkg::op_move, 2'b00}:          next_state = s_b_rm;
					{cpu_pkg::op_alu, cpu_pkg::alu_add},
					{cpu_pkg::op_alu, cpu_pkg::alu_and}: next_state = s_a_rn;
					{cpu_pkg::op_alu, cpu_pkg::alu_not}: next_state = s_b_rm; // mvn
					{cpu_pkg::op_ldr, 2'b00},
					{cpu_pkg::op_str, 2'b00}:           next_state = s_a_rn;
					default:                            next_state = s_halt; // cmp lands here
				endcase
			end
			s_mov_imm:   next_state = s_if1;
			s_a_rn:      next_state = (instr.alu.opcode == cpu_pkg::op_alu) ? s_b_rm : s_addr;
			s_b_rm:      next_state = (instr.alu.opcode == cpu_pkg::op_move) ? s_pass : s_alu;
			s_alu:       next_state = s_wb_rd;
			s_pass:      next_state = (instr.alu.opcode == cpu_pkg::op_str) ? s_st_write : s_wb_rd;
			s_wb_rd:     next_state = s_if1;
			s_addr:      next_state = s_mem_addr;
			s_mem_addr:  next_state = (instr.alu.opcode == cpu_pkg::op_ldr) ? s_ld_read : s_st_b;
			s_ld_read:   next_state = s_ld_wb;
			s_ld_wb:     next_state = s_if1;
			s_st_b:      next_state = s_pass;
			s_st_write:  next_state = s_if1;
			default:     next_state = s_halt;
		endcase
	end

	// moore outputs, everything idle unless a state asks for it
	always_comb begin
		dp_ctrl = '0;
		fetch_ctrl = '0;
		mem_cmd = cpu_pkg::mem_none;
		case (state)
			s_reset: begin
				fetch_ctrl.reset_pc = 1'b1;
				fetch_ctrl.load_pc = 1'b1;
			end
			s_if1: begin
				fetch_ctrl.addr_sel = 1'b1;
				mem_cmd = cpu_pkg::mem_read;
			end
			s_if2: begin
				fetch_ctrl.addr_sel = 1'b1;
				fetch_ctrl.load_ir = 1'b1; // data from the if1 read
				mem_cmd = cpu_pkg::mem_read;
			end
			s_update_pc: fetch_ctrl.load_pc = 1'b1;
			s_mov_imm: begin
				dp_ctrl.reg_sel = cpu_pkg::sel_rn;
				dp_ctrl.wb_sel = cpu_pkg::wb_imm8;
				dp_ctrl.write = 1'b1;
			end
			s_a_rn: begin
				dp_ctrl.reg_sel = cpu_pkg::sel_rn;
				dp_ctrl.load_a = 1'b1;
			end
			s_b_rm: begin
				dp_ctrl.reg_sel = cpu_pkg::sel_rm;
				dp_ctrl.load_b = 1'b1;
			end
			s_alu:  dp_ctrl.load_c = 1'b1;
			s_pass: begin
				dp_ctrl.a_zero = 1'b1;
				dp_ctrl.load_c = 1'b1;
			end
			s_wb_rd: begin
				dp_ctrl.reg_sel = cpu_pkg::sel_rd;
				dp_ctrl.wb_sel = cpu_pkg::wb_alu;
				dp_ctrl.write = 1'b1;
			end
			s_addr: begin
				dp_ctrl.b_imm5 = 1'b1;
				dp_ctrl.load_c = 1'b1;
			end
			s_mem_addr: fetch_ctrl.load_addr = 1'b1;
			s_ld_read:  mem_cmd = cpu_pkg::mem_read; // data address register on the bus
			s_ld_wb: begin
				dp_ctrl.reg_sel = cpu_pkg::sel_rd;
				dp_ctrl.wb_sel = cpu_pkg::wb_mem;
				dp_ctrl.write = 1'b1;
			end
			s_st_b: begin
				dp_ctrl.reg_sel = cpu_pkg::sel_rd;
				dp_ctrl.load_b = 1'b1;
			end
			s_st_write: mem_cmd = cpu_pkg::mem_write;
			default: ; // halt keeps every output idle
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/datapath.sv
// execute datapath
`default_nettype none

module datapath (
	input  logic               clk,
	input  cpu_pkg::dp_ctrl_t  ctrl,
	input  cpu_pkg::instr_u    instr,
	input  cpu_pkg::word_t     read_data,
	output cpu_pkg::word_t     alu_out
);

	cpu_pkg::reg_idx_t reg_num;
	cpu_pkg::shift_e   shift_code;
	cpu_pkg::word_t    sx_imm8;
	cpu_pkg::word_t    sx_imm5;
	cpu_pkg::word_t    regs [8];
	cpu_pkg::word_t    rd_value;
	cpu_pkg::word_t    wb_value;
	cpu_pkg::word_t    a_reg;
	cpu_pkg::word_t    b_reg;
	cpu_pkg::word_t    b_shifted;
	cpu_pkg::word_t    alu_a;
	cpu_pkg::word_t    alu_b;
	cpu_pkg::word_t    alu_result;

	always_comb begin
		case (ctrl.reg_sel)
			cpu_pkg::sel_rn: reg_num = instr.imm.rn;
			cpu_pkg::sel_rd: reg_num = instr.alu.rd;
			default:         reg_num = instr.alu.rm;
		endcase
	end

	assign sx_imm8 = {{(cpu_pkg::data_w-8){instr.imm.imm8[7]}}, instr.imm.imm8};
	assign sx_imm5 = {{(cpu_pkg::data_w-5){instr.imm.imm8[4]}}, instr.imm.imm8[4:0]};

	// ldr and str carry imm5 where the shift field would be
	assign shift_code = (instr.alu.opcode inside {cpu_pkg::op_ldr, cpu_pkg::op_str}) ?
		cpu_pkg::sh_none : instr.alu.shift;

	always_comb begin
		case (ctrl.wb_sel)
			cpu_pkg::wb_imm8: wb_value = sx_imm8;
			cpu_pkg::wb_mem:  wb_value = read_data;
			default:          wb_value = alu_out;
		endcase
	end

	// single ported register file, read and write share one index
	always_ff @(posedge clk) begin
		if (ctrl.write) begin
			regs[reg_num] <= wb_value;
		end
	end

	assign rd_value = regs[reg_num];

	always_ff @(posedge clk) begin
		if (ctrl.load_a) begin
			a_reg <= rd_value;
		end
		if (ctrl.load_b) begin
			b_reg <= rd_value;
		end
		if (ctrl.load_c) begin
			alu_out <= alu_result;
		end
	end

	always_comb begin
		case (shift_code)
			cpu_pkg::sh_left:  b_shifted = {b_reg[cpu_pkg::data_w-2:0], 1'b0};
			cpu_pkg::sh_right: b_shifted = {1'b0, b_reg[cpu_pkg::data_w-1:1]};
			cpu_pkg::sh_arith: b_shifted = {b_reg[cpu_pkg::data_w-1], b_reg[cpu_pkg::data_w-1:1]};
			default:           b_shifted = b_reg;
		endcase
	end

	assign alu_a = ctrl.a_zero ? '0 : a_reg; // mov and str pass b through
	assign alu_b = ctrl.b_imm5 ? sx_imm5 : b_shifted;

	always_comb begin
		case (instr.alu.op)
			cpu_pkg::alu_and: alu_result = alu_a & alu_b;
			cpu_pkg::alu_not: alu_result = ~alu_b;
			default:          alu_result = alu_a + alu_b; // add, also address calc
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
// instruction fetch and addressing
`default_nettype none

module fetch_unit #(
	parameter int unsigned addr_w = 9
) (
	input  logic                  clk,
	input  cpu_pkg::fetch_ctrl_t  ctrl,
	input  cpu_pkg::word_t        read_data,
	input  cpu_pkg::word_t        data_addr_src,
	output cpu_pkg::instr_u       instr,
	output logic [addr_w-1:0]     mem_addr
);

	logic [addr_w-1:0] pc;
	logic [addr_w-1:0] next_pc;
	logic [addr_w-1:0] data_addr;

	// cleared through reset_pc while the controller sits in its reset state
	assign next_pc = ctrl.reset_pc ? '0 : pc + addr_w'(1);

	always_ff @(posedge clk) begin
		if (ctrl.load_pc) begin
			pc <= next_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.load_ir) begin
			instr <= read_data; // word answering the read at the pc
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.load_addr) begin
			data_addr <= data_addr_src[addr_w-1:0]; // low bits of c
		end
	end

	assign mem_addr = ctrl.addr_sel ? pc : data_addr;

endmodule

`default_nettype wire

//--- hdl/cpu_pkg.sv
// multicycle cpu shared types
`default_nettype none

package cpu_pkg;

	localparam int unsigned data_w = 16;

	typedef logic [data_w-1:0] word_t;
	typedef logic [2:0] reg_idx_t;

	typedef enum logic [2:0] {
		op_ldr  = 3'b011,
		op_str  = 3'b100,
		op_alu  = 3'b101,
		op_move = 3'b110,
		op_halt = 3'b111
	} opcode_e;

	typedef enum logic [1:0] {
		alu_add = 2'b00,
		alu_sub = 2'b01, // encoding of cmp, decoded as halt
		alu_and = 2'b10,
		alu_not = 2'b11
	} alu_op_e;

	typedef enum logic [1:0] {sh_none, sh_left, sh_right, sh_arith} shift_e;

	// register to register format, also used by mov shifted and mvn
	typedef struct packed {
		opcode_e opcode;
		alu_op_e op;
		reg_idx_t rn;
		reg_idx_t rd;
		shift_e shift;
		reg_idx_t rm;
	} alu_fmt_t;

	// immediate format; ldr and str take imm5 from the low bits of imm8
	typedef struct packed {
		opcode_e opcode;
		logic [1:0] op;
		reg_idx_t rn;
		logic [7:0] imm8;
	} imm_fmt_t;

	typedef union packed {
		alu_fmt_t alu;
		imm_fmt_t imm;
	} instr_u;

	typedef enum logic [1:0] {
		mem_none  = 2'b00,
		mem_read  = 2'b01,
		mem_write = 2'b10
	} mem_cmd_e;

	typedef enum logic [1:0] {sel_rn, sel_rd, sel_rm} reg_sel_e;

	typedef enum logic [1:0] {wb_alu, wb_imm8, wb_mem} wb_sel_e;

	typedef struct packed {
		reg_sel_e reg_sel; // register file index source
		wb_sel_e wb_sel;
		logic write;
		logic load_a;
		logic load_b;
		logic load_c;
		logic a_zero; // alu a input forced to zero
		logic b_imm5; // alu b input takes imm5 instead of shifted b
	} dp_ctrl_t;

	typedef struct packed {
		logic load_ir;
		logic load_pc;
		logic reset_pc;
		logic load_addr;
		logic addr_sel; // 1 drives the pc onto mem_addr
	} fetch_ctrl_t;

endpackage

`default_nettype wire
